/* bk_top.f */
+incdir+design
design/bk_types_pkg.sv
design/bk_ctrl_pkg.sv
design/bk_buf_if.sv
design/bk_sequencer.sv
design/bk_sector_counter.sv
design/bk_ram.sv
design/bk_top.sv
tests/bk_assertions.sv
tests/bk_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := bk_tb
FILELIST  := bk_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
FAIL_MSG  := FAIL: see errors above

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/bk_tb.sv */
// Testbench for the backup RAM block with host model, RAM model and checks
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_tb
	import bk_types_pkg::*;
();

	localparam int CORE_BYTES   = 2 ** $bits(core_addr_t);
	localparam int SECTOR_WORDS = 2 ** $bits(buf_addr_t);
	localparam int MAX_DELAY    = 7;
	localparam int REQ_WAIT     = 64;
	localparam int RAND_READS   = 512;
	localparam int N_TRANSFERS  = 3;
	localparam int CORE_CYCLES  = 2 * CORE_BYTES + RAND_READS + 64;
	localparam int XFER_CYCLES  = N_TRANSFERS * `BK_SECTORS * (SECTOR_WORDS + MAX_DELAY + 4);
	localparam int WATCHDOG_NS  = 2 * 20 * (16 + CORE_CYCLES + XFER_CYCLES + 100);

	logic       clk_sys = 1'b0;
	logic       reset;
	core_addr_t core_addr;
	core_byte_t core_wdata;
	logic       core_we;
	core_byte_t core_rdata;
	logic       bk_enable;
	logic       load_req;
	logic       save_req;
	logic       autosave_en;
	logic       osd_open;
	logic       format_req;
	logic       sd_rd;
	logic       sd_wr;
	lba_t       sd_lba;
	logic       sd_ack;
	buf_addr_t  buff_addr;
	buf_word_t  buff_dout;
	buf_word_t  buff_din;
	logic       buff_wr;
	logic       busy;
	logic       loading;
	logic       pending;

	// Reference copy of the save RAM
	core_byte_t  mdl [CORE_BYTES];
	logic [15:0] lfsr_state;
	int          err_value;
	int          err_other;
	int          err_assert;

	bk_top i_dut (.*);

	always #10 clk_sys = ~clk_sys;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			err_value++;
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Low half is the even byte
	function automatic buf_word_t model_word(input sector_t s, input buf_addr_t w);
		return {mdl[{s, w, 1'b1}], mdl[{s, w, 1'b0}]};
	endfunction

	function automatic buf_word_t header_word(input int k);
		case (k)
			0:       return `BK_HDR_W0;
			1:       return `BK_HDR_W1;
			2:       return `BK_HDR_W2;
			default: return `BK_HDR_W3;
		endcase
	endfunction

	// All tasks start and end just after a falling edge
	task automatic core_write(input core_addr_t a, input core_byte_t d);
		core_addr  = a;
		core_wdata = d;
		core_we    = 1'b1;
		mdl[a]     = d;
		@(negedge clk_sys);
		core_we = 1'b0;
	endtask

	task automatic core_read_check(input core_addr_t a);
		core_addr = a;
		@(negedge clk_sys);
		check_val("core_rdata", 32'(core_rdata), 32'(mdl[a]));
	endtask

	//////////////////////////////
	// Host model
	//////////////////////////////

	task automatic serve_transfer(input logic is_save);
		int          s;
		int          w;
		int          waited;
		logic [31:0] r;
		sector_t     sec;
		buf_addr_t   wa;
		buf_word_t   word;
		for (s = 0; s < `BK_SECTORS; s++) begin
			waited = 0;
			while (!(sd_rd || sd_wr) && waited < REQ_WAIT) begin
				@(negedge clk_sys);
				waited++;
			end
			if (!(sd_rd || sd_wr)) begin
				err_other++;
				$display("No host request for sector %0d within %0d cycles", s, REQ_WAIT);
				return;
			end
			check_val("sd_wr", 32'(sd_wr), 32'(is_save));
			check_val("sd_rd", 32'(sd_rd), 32'(!is_save));
			check_val("sd_lba", sd_lba, 32'(s));
			check_val("loading", 32'(loading), 32'(!is_save));
			// Host latency before the ack
			rand_bits(3, r);
			repeat (r[2:0]) @(negedge clk_sys);
			sec    = sector_t'(s);
			sd_ack = 1'b1;
			for (w = 0; w < SECTOR_WORDS; w++) begin
				wa        = buf_addr_t'(w);
				buff_addr = wa;
				if (!is_save) begin
					rand_bits(16, r);
					word               = buf_word_t'(r);
					buff_wr            = 1'b1;
					buff_dout          = word;
					mdl[{sec, wa, 1'b0}] = word[7:0];
					mdl[{sec, wa, 1'b1}] = word[15:8];
				end
				@(negedge clk_sys);
				if (is_save)
					check_val("buff_din", 32'(buff_din), 32'(model_word(sec, wa)));
			end
			sd_ack  = 1'b0;
			buff_wr = 1'b0;
		end
		waited = 0;
		while (busy && waited < REQ_WAIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (busy) begin
			err_other++;
			$display("busy stayed high after the last sector");
		end
		check_val("loading", 32'(loading), 32'd0);
	endtask

	task automatic check_no_request();
		int i;
		for (i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr || busy) begin
				err_other++;
				$display("A transfer started while bk_enable was low");
				return;
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int          i;
		logic [31:0] r;
		core_addr_t  a;
		buf_word_t   hw;
		reset       = 1'b1;
		core_addr   = '0;
		core_wdata  = '0;
		core_we     = 1'b0;
		bk_enable   = 1'b0;
		load_req    = 1'b0;
		save_req    = 1'b0;
		autosave_en = 1'b0;
		osd_open    = 1'b0;
		format_req  = 1'b0;
		sd_ack      = 1'b0;
		buff_addr   = '0;
		buff_dout   = '0;
		buff_wr     = 1'b0;
		lfsr_state  = 16'd36;
		err_value   = 0;
		err_other   = 0;
		repeat (16) @(negedge clk_sys);
		reset     = 1'b0;
		bk_enable = 1'b1;
		@(negedge clk_sys);

		// Reset state and a read back of the filled core port
		check_val("sd_rd", 32'(sd_rd), 32'd0);
		check_val("sd_wr", 32'(sd_wr), 32'd0);
		check_val("busy", 32'(busy), 32'd0);
		check_val("loading", 32'(loading), 32'd0);
		check_val("pending", 32'(pending), 32'd0);
		for (i = 0; i < CORE_BYTES; i++) begin
			rand_bits(8, r);
			core_write(core_addr_t'(i), core_byte_t'(r));
		end
		for (i = 0; i < RAND_READS; i++) begin
			rand_bits(11, r);
			core_read_check(core_addr_t'(r));
		end

		// Save of four sectors
		check_val("pending", 32'(pending), 32'd1);
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		serve_transfer(1'b1);
		check_val("pending", 32'(pending), 32'd0);

		// Load of fresh host words
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		serve_transfer(1'b0);
		for (i = 0; i < CORE_BYTES; i++)
			core_read_check(core_addr_t'(i));

		// Format header in words 0 to 3
		format_req = 1'b1;
		repeat (`BK_FORMAT_WORDS + 2) @(negedge clk_sys);
		format_req = 1'b0;
		for (i = 0; i < `BK_FORMAT_WORDS; i++) begin
			hw                           = header_word(i);
			mdl[core_addr_t'(2 * i)]     = hw[7:0];
			mdl[core_addr_t'(2 * i + 1)] = hw[15:8];
		end
		for (i = 0; i < 2 * `BK_FORMAT_WORDS; i++)
			core_read_check(core_addr_t'(i));

		// Autosave when the menu opens
		rand_bits(11, r);
		a = core_addr_t'(r);
		rand_bits(8, r);
		core_write(a, core_byte_t'(r));
		check_val("pending", 32'(pending), 32'd1);
		autosave_en = 1'b1;
		@(negedge clk_sys);
		osd_open    = 1'b1;
		serve_transfer(1'b1);
		check_val("pending", 32'(pending), 32'd0);
		osd_open    = 1'b0;
		autosave_en = 1'b0;

		// Image not writable
		bk_enable = 1'b0;
		load_req  = 1'b1;
		check_no_request();
		load_req = 1'b0;
		save_req = 1'b1;
		check_no_request();
		save_req = 1'b0;
		@(negedge clk_sys);
		bk_enable = 1'b1;
		@(negedge clk_sys);

		err_assert = i_dut.i_sequencer.i_seq_checks.fail_count;
		$display("Errors: %0d value, %0d other, %0d assertion",
			err_value, err_other, err_assert);
		if (err_value + err_other + err_assert == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* tests/bk_assertions.sv */
// Concurrent checks on the save and load sequencer host handshake
`timescale 1ns/1ps

module bk_assertions (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic busy,
	input logic loading
);

	// Failed checks so far
	int fail_count = 0;

	// One direction at a time
	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
	else begin
		$error("sd_rd and sd_wr are high together");
		fail_count = fail_count + 1;
	end

	a_loading_busy: assert property (@(posedge clk_sys) disable iff (reset)
		loading |-> busy)
	else begin
		$error("loading is high while busy is low");
		fail_count = fail_count + 1;
	end

	// Request gone the cycle after ack is seen
	a_request_drop: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) && sd_ack |=> !(sd_rd || sd_wr))
	else begin
		$error("Request still high one cycle after ack");
		fail_count = fail_count + 1;
	end

endmodule

bind bk_sequencer bk_assertions i_seq_checks (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.sd_ack  (sd_ack),
	.busy    (busy),
	.loading (loading)
);

/* design/bk_top.sv */
// Backup RAM block top level with core port, host sector port and sequencer
`timescale 1ns/1ps

module bk_top
	import bk_types_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,

	// Core byte port
	input  core_addr_t core_addr,
	input  core_byte_t core_wdata,
	input  logic       core_we,
	output core_byte_t core_rdata,

	// Menu and image controls
	input  logic       bk_enable,
	input  logic       load_req,
	input  logic       save_req,
	input  logic       autosave_en,
	input  logic       osd_open,
	input  logic       format_req,

	// Host sector interface
	output logic       sd_rd,
	output logic       sd_wr,
	output lba_t       sd_lba,
	input  logic       sd_ack,
	input  buf_addr_t  buff_addr,
	input  buf_word_t  buff_dout,
	output buf_word_t  buff_din,
	input  logic       buff_wr,

	// Status
	output logic       busy,
	output logic       loading,
	output logic       pending
);

	logic    clear;
	logic    step;
	logic    last;
	sector_t sector;

	bk_buf_if buf_bus ();

	//////////////////////////////
	// Host buffer bundle
	//////////////////////////////

	assign buf_bus.buff_addr = buff_addr;
	assign buf_bus.buff_dout = buff_dout;
	assign buf_bus.buff_wr   = buff_wr;
	assign buf_bus.sd_ack    = sd_ack;
	assign buf_bus.sector    = sector;
	assign buff_din          = buf_bus.buff_din;

	// Image sits at the start of the save file
	assign sd_lba = lba_t'(sector);

	bk_sequencer i_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bk_enable   (bk_enable),
		.load_req    (load_req),
		.save_req    (save_req),
		.autosave_en (autosave_en),
		.osd_open    (osd_open),
		.core_we     (core_we),
		.sd_ack      (sd_ack),
		.last        (last),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.clear       (clear),
		.step        (step),
		.busy        (busy),
		.loading     (loading),
		.pending     (pending)
	);

	bk_sector_counter i_counter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (clear),
		.step    (step),
		.sector  (sector),
		.last    (last)
	);

	bk_ram i_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.core_addr  (core_addr),
		.core_wdata (core_wdata),
		.core_we    (core_we),
		.format_req (format_req),
		.core_rdata (core_rdata),
		.host_buf   (buf_bus)
	);

endmodule

/* design/bk_ram.sv */
// Save RAM with a byte port for the core, a word port for the host and a format writer
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_ram
	import bk_types_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  core_addr_t core_addr,
	input  core_byte_t core_wdata,
	input  logic       core_we,
	input  logic       format_req,
	output core_byte_t core_rdata,
	bk_buf_if.ram      host_buf
);

	// Word index across the whole image
	typedef logic [$bits(sector_t)+$bits(buf_addr_t)-1:0] word_idx_t;
	typedef logic [$clog2(`BK_FORMAT_WORDS)-1:0] fmt_step_t;

	// Even bytes in the low bank, odd bytes in the high bank
	core_byte_t mem_lo [2**$bits(word_idx_t)];
	core_byte_t mem_hi [2**$bits(word_idx_t)];

	logic      fmt_q;
	logic      fmt_busy;
	fmt_step_t fmt_step;
	buf_word_t hdr_word;
	word_idx_t host_idx;
	word_idx_t core_idx;
	word_idx_t wr_idx;
	buf_word_t wr_word;
	logic      wr_en;

	//////////////////////////////
	// Format writer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fmt_q    <= 1'b0;
			fmt_busy <= 1'b0;
			fmt_step <= '0;
		end else begin
			fmt_q <= format_req;
			if (format_req && !fmt_q) begin
				fmt_busy <= 1'b1;
				fmt_step <= '0;
			end else if (fmt_busy) begin
				fmt_step <= fmt_step + fmt_step_t'(1);
				if (fmt_step == fmt_step_t'(`BK_FORMAT_WORDS - 1))
					fmt_busy <= 1'b0;
			end
		end
	end

	always_comb begin
		case (fmt_step)
			fmt_step_t'(0): hdr_word = `BK_HDR_W0;
			fmt_step_t'(1): hdr_word = `BK_HDR_W1;
			fmt_step_t'(2): hdr_word = `BK_HDR_W2;
			default:        hdr_word = `BK_HDR_W3;
		endcase
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	assign host_idx = {host_buf.sector, host_buf.buff_addr};
	assign core_idx = core_addr[$bits(core_addr_t)-1:1];

	// Format owns the word write side while it runs
	assign wr_en   = fmt_busy | (host_buf.buff_wr & host_buf.sd_ack);
	assign wr_idx  = fmt_busy ? word_idx_t'(fmt_step) : host_idx;
	assign wr_word = fmt_busy ? hdr_word : host_buf.buff_dout;

	always_ff @(posedge clk_sys) begin
		// Core byte port
		if (core_we) begin
			if (core_addr[0])
				mem_hi[core_idx] <= core_wdata;
			else
				mem_lo[core_idx] <= core_wdata;
		end
		core_rdata <= core_addr[0] ? mem_hi[core_idx] : mem_lo[core_idx];

		// Host word port
		if (wr_en) begin
			mem_lo[wr_idx] <= wr_word[7:0];
			mem_hi[wr_idx] <= wr_word[15:8];
		end
		host_buf.buff_din <= {mem_hi[host_idx], mem_lo[host_idx]};
	end

endmodule

/* design/bk_sector_counter.sv */
// Sector number register for the host transfer
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_sector_counter
	import bk_types_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    clear,
	input  logic    step,
	output sector_t sector,
	output logic    last
);

	// Clear has priority so a start begins at sector 0
	always_ff @(posedge clk_sys) begin
		if (reset)
			sector <= '0;
		else if (clear)
			sector <= '0;
		else if (step)
			sector <= sector + sector_t'(1);
	end

	// Final sector of the image
	assign last = (sector == sector_t'(`BK_SECTORS - 1));

endmodule

/* design/bk_sequencer.sv */
// Save and load sequencer with pending flag and autosave trigger
`timescale 1ns/1ps

module bk_sequencer
	import bk_ctrl_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  logic bk_enable,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave_en,
	input  logic osd_open,
	input  logic core_we,
	input  logic sd_ack,
	input  logic last,
	output logic sd_rd,
	output logic sd_wr,
	output logic clear,
	output logic step,
	output logic busy,
	output logic loading,
	output logic pending
);

	bk_state_e state;
	bk_dir_e   dir;

	logic load_q;
	logic save_q;
	logic auto_q;
	logic ack_q;
	logic auto_cond;
	logic load_rise;
	logic save_rise;
	logic auto_rise;
	logic ack_rise;
	logic ack_fall;
	logic start;
	logic start_save;

	//////////////////////////////
	// Trigger and ack edges
	//////////////////////////////

	// Autosave fires when the menu opens over unsaved data
	assign auto_cond = pending & osd_open & autosave_en;

	assign load_rise = load_req & ~load_q;
	assign save_rise = save_req & ~save_q;
	assign auto_rise = auto_cond & ~auto_q;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ~sd_ack & ack_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
			auto_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_req;
			auto_q <= auto_cond;
			ack_q  <= sd_ack;
		end
	end

	// Load wins when both edges land together
	assign start      = (state == IDLE) & bk_enable & (load_rise | save_rise | auto_rise);
	assign start_save = start & ~load_rise;

	// Sector is valid in the cycle the request rises
	assign clear = start;
	assign step  = (state == ACKED) & ack_fall & ~last;

	//////////////////////////////
	// Transfer FSM
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
			dir   <= DIR_SAVE;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= REQUEST;
						dir   <= load_rise ? DIR_LOAD : DIR_SAVE;
					end
				end
				REQUEST, NEXT: begin
					if (ack_rise)
						state <= ACKED;
				end
				ACKED: begin
					// Host done with this sector
					if (ack_fall)
						state <= last ? IDLE : NEXT;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign sd_rd   = ((state == REQUEST) || (state == NEXT)) && (dir == DIR_LOAD);
	assign sd_wr   = ((state == REQUEST) || (state == NEXT)) && (dir == DIR_SAVE);
	assign busy    = (state != IDLE);
	assign loading = (state != IDLE) && (dir == DIR_LOAD);

	// Unsaved core writes counted only while the game runs
	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (start_save)
			pending <= 1'b0;
		else if (bk_enable && !osd_open && core_we)
			pending <= 1'b1;
	end

endmodule

/* design/bk_buf_if.sv */
// Host sector buffer bundle between the top level and the save RAM
`timescale 1ns/1ps

interface bk_buf_if
	import bk_types_pkg::*;
();

	buf_addr_t buff_addr;
	buf_word_t buff_dout;
	buf_word_t buff_din;
	logic      buff_wr;
	logic      sd_ack;
	sector_t   sector;

	// Host side drives address, write data and strobes
	modport host (
		output buff_addr, buff_dout, buff_wr, sd_ack, sector,
		input  buff_din
	);

	// RAM side returns read data one cycle after the address
	modport ram (
		input  buff_addr, buff_dout, buff_wr, sd_ack, sector,
		output buff_din
	);

endinterface

/* design/bk_ctrl_pkg.sv */
// Backup RAM sequencer control types
package bk_ctrl_pkg;

	// REQUEST holds the first request, NEXT the ones that follow a sector
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		ACKED,
		NEXT
	} bk_state_e;

	typedef enum logic {
		DIR_LOAD,
		DIR_SAVE
	} bk_dir_e;

endpackage

/* design/bk_types_pkg.sv */
// Backup RAM data types for the core byte port and the host sector port
`include "bk_defines.svh"

package bk_types_pkg;

	// Core side addressed by byte over 2 KB
	typedef logic [10:0] core_addr_t;
	typedef logic [7:0]  core_byte_t;

	// Host side with 256 words per sector
	typedef logic [7:0]  buf_addr_t;
	typedef logic [15:0] buf_word_t;

	// Sector inside the image
	typedef logic [$clog2(`BK_SECTORS)-1:0] sector_t;

	// Block address as the host sees it
	typedef logic [31:0] lba_t;

endpackage

/* design/bk_defines.svh */
// Backup RAM constants for the sector count and the format header
`ifndef BK_DEFINES_SVH
`define BK_DEFINES_SVH

//////////////////////////////
// Image layout
//////////////////////////////

// Sectors of 512 bytes per save image
`define BK_SECTORS 4

//////////////////////////////
// Format header
//////////////////////////////

`define BK_FORMAT_WORDS 4

// Default header of "HUBM" and the free area pointer
`define BK_HDR_W0 16'h5548
`define BK_HDR_W1 16'h4D42
`define BK_HDR_W2 16'h8800
`define BK_HDR_W3 16'h8010

`endif
